// ==== rsa_uart.f ====
+incdir+tests
verilog/rsa_pkg.sv
verilog/avm_uart_pkg.sv
verilog/rsa_mod_prep.sv
verilog/rsa_mont_mult.sv
verilog/rsa_modexp_core.sv
verilog/rsa_uart_ctrl.sv
verilog/rsa_uart_top.sv
tests/tb_rsa_uart.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_rsa_uart \
    -f rsa_uart.f -o tb_rsa_uart
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_rsa_uart)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1

// ==== tests/tb_rsa_model.svh ====
`ifndef TB_RSA_MODEL_SVH
`define TB_RSA_MODEL_SVH

    logic [31:0] lcg_state = 32'd6;
    avm_uart_pkg::byte_t rx_q[$];
    avm_uart_pkg::byte_t tx_q[$];
    int stat_delay_max = 4;
    int wait_left = 0;
    int rx_delay = 0;
    int tx_delay = 0;
    logic in_xfer = 1'b0;
    logic done_pend = 1'b0;
    avm_uart_pkg::avm_cmd_t pend;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int pick_below(input int k);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[30:16]) % k;
    endfunction

    // reference result by plain square-and-multiply on double-width values.
    function automatic rsa_pkg::rsa_word_t model_modexp(input rsa_pkg::rsa_word_t c,
                                                        input rsa_pkg::rsa_word_t e,
                                                        input rsa_pkg::rsa_word_t n);
        logic [511:0] r;
        logic [511:0] b;
        logic [511:0] m;
        int i;
        m = {256'd0, n};
        r = 512'd1;
        b = {256'd0, c} % m;
        for (i = 0; i < 256; i++) begin
            if (e[i]) begin
                r = (r * b) % m;
            end
            b = (b * b) % m;
        end
        return r[255:0];
    endfunction

    // one bus cycle of the UART, called just after each rising edge.
    task automatic uart_step();
        avm_uart_pkg::avm_cmd_t cur;
        avm_uart_pkg::avm_data_t status;
        cur = '{address: avm_address, read: avm_read, write: avm_write,
                writedata: avm_writedata};
        if (done_pend && pend.read && pend.address == avm_uart_pkg::rx_base) begin
            if (rx_q.size() == 0) begin
                $display("receive register was read with no byte waiting");
                err_cnt++;
            end else begin
                void'(rx_q.pop_front());
            end
            rx_delay = pick_below(stat_delay_max);
        end
        if (done_pend && pend.write) begin
            check_addr(avm_uart_pkg::tx_base, pend.address);
            if (rx_q.size() != 0) begin
                $display("byte written while %0d received bytes were unread", rx_q.size());
                err_cnt++;
            end
            tx_q.push_back(pend.writedata[7:0]);
            tx_delay = pick_below(stat_delay_max);
        end
        if (rx_delay > 0) begin
            rx_delay--;
        end
        if (tx_delay > 0) begin
            tx_delay--;
        end
        status = '0;
        status[avm_uart_pkg::rx_ok_bit] = (rx_delay == 0) && (rx_q.size() != 0);
        status[avm_uart_pkg::tx_ok_bit] = (tx_delay == 0);
        if ((cur.read || cur.write) && !in_xfer) begin
            in_xfer = 1'b1;
            wait_left = pick_below(4);
        end
        done_pend = in_xfer && (wait_left == 0);
        avm_waitrequest = in_xfer && (wait_left != 0);
        if (done_pend) begin
            in_xfer = 1'b0;
            pend = cur;
        end else if (in_xfer) begin
            wait_left--;
        end
        if (!done_pend) begin
            avm_readdata = lcg_next();
        end else if (cur.address == avm_uart_pkg::status_base) begin
            avm_readdata = status;
        end else begin
            avm_readdata = avm_uart_pkg::avm_data_t'((rx_q.size() != 0) ? rx_q[0] : 8'h00);
        end
    endtask

`endif

// ==== tests/tb_rsa_uart.sv ====
`timescale 1ns/1ps

module tb_rsa_uart;

    // one block needs about 66k cycles, so 80k per block covers six blocks.
    localparam int block_cycles = 80000;
    localparam int max_cycles = 6 * block_cycles;

    logic avm_clk = 1'b0;
    logic avm_rst = 1'b1;
    avm_uart_pkg::avm_addr_t avm_address;
    logic avm_read;
    avm_uart_pkg::avm_data_t avm_readdata = '0;
    logic avm_write;
    avm_uart_pkg::avm_data_t avm_writedata;
    logic avm_waitrequest = 1'b1;

    logic rst_req = 1'b1;
    int err_cnt = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int cycle_cnt = 0;

    `include "tb_rsa_model.svh"

    rsa_uart_top UUT (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest)
    );

    always #2 avm_clk = ~avm_clk;

    // all DUT inputs change here, half a nanosecond after the edge.
    always @(posedge avm_clk) begin
        #0.5;
        avm_rst = rst_req;
        if (rst_req) begin
            in_xfer = 1'b0;
            done_pend = 1'b0;
            rx_delay = 0;
            tx_delay = 0;
            avm_waitrequest = 1'b0;
            avm_readdata = '0;
        end else begin
            uart_step();
        end
    end

    always @(posedge avm_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_byte(input int idx, input avm_uart_pkg::byte_t expected,
                              input avm_uart_pkg::byte_t actual);
        if (actual !== expected) begin
            $display("Mismatch avm_writedata byte %0d: expected %h, got %h",
                     idx, expected, actual);
            err_cnt++;
        end
    endtask

    task automatic check_addr(input avm_uart_pkg::avm_addr_t expected,
                              input avm_uart_pkg::avm_addr_t actual);
        if (actual !== expected) begin
            $display("Mismatch avm_address: expected %h, got %h", expected, actual);
            err_cnt++;
        end
    endtask

    function automatic rsa_pkg::rsa_word_t random_word();
        rsa_pkg::rsa_word_t w;
        int i;
        for (i = 0; i < 8; i++) begin
            w[32*i +: 32] = lcg_next();
        end
        return w;
    endfunction

    task automatic push_word(input rsa_pkg::rsa_word_t w);
        int i;
        for (i = avm_uart_pkg::key_bytes - 1; i >= 0; i--) begin
            rx_q.push_back(w[8*i +: 8]);
        end
    endtask

    // sends one cipher block and checks the 31 plaintext bytes that come back.
    task automatic run_block(input string name, input rsa_pkg::rsa_word_t n,
                             input rsa_pkg::rsa_word_t d);
        rsa_pkg::rsa_word_t c;
        rsa_pkg::rsa_word_t p;
        int errs;
        int i;
        errs = err_cnt;
        c = random_word();
        c[255:248] = '0;
        p = model_modexp(c, d, n);
        push_word(c);
        while (tx_q.size() < avm_uart_pkg::out_bytes) begin
            @(posedge avm_clk);
        end
        repeat (100) @(posedge avm_clk);
        if (tx_q.size() != avm_uart_pkg::out_bytes) begin
            $display("%0d bytes were written instead of %0d", tx_q.size(),
                     avm_uart_pkg::out_bytes);
            err_cnt++;
        end
        for (i = 0; i < avm_uart_pkg::out_bytes; i++) begin
            check_byte(i, p[247 - 8*i -: 8], tx_q[i]);
        end
        tx_q.delete();
        if (err_cnt == errs) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", name, err_cnt - errs);
        end
    endtask

    initial begin
        rsa_pkg::rsa_word_t n;
        rsa_pkg::rsa_word_t d;
        repeat (10) @(posedge avm_clk);
        rst_req = 1'b0;
        n = random_word();
        n[255] = 1'b1;
        n[0] = 1'b1;
        d = random_word();
        push_word(n);
        push_word(d);
        run_block("1 key load and first block", n, d);
        run_block("2 second block with the same key", n, d);
        run_block("3 third block with the same key", n, d);
        stat_delay_max = 24;
        run_block("4 long status delays", n, d);
        stat_delay_max = 4;

        // abandon a block while the core is busy, then load a new key.
        push_word(random_word() >> 8);
        while (rx_q.size() != 0) begin
            @(posedge avm_clk);
        end
        repeat (2000) @(posedge avm_clk);
        rst_req = 1'b1;
        rx_q.delete();
        tx_q.delete();
        repeat (10) @(posedge avm_clk);
        rst_req = 1'b0;
        n = random_word();
        n[255] = 1'b1;
        n[0] = 1'b1;
        d = rsa_pkg::rsa_word_t'(1);
        push_word(n);
        push_word(d);
        run_block("5 reset and new key with d equal to 1", n, d);

        $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/avm_uart_pkg.sv ====
package avm_uart_pkg;

    typedef logic [4:0] avm_addr_t;
    typedef logic [31:0] avm_data_t;
    typedef logic [7:0] byte_t;

    // byte addresses of the UART registers.
    localparam avm_addr_t rx_base = 5'd0;
    localparam avm_addr_t tx_base = 5'd4;
    localparam avm_addr_t status_base = 5'd8;

    // ready flags in the status register.
    localparam int tx_ok_bit = 6;
    localparam int rx_ok_bit = 7;

    // bytes per key or cipher block, and plaintext bytes sent back.
    localparam int key_bytes = 32;
    localparam int out_bytes = 31;

    // one registered Avalon-MM master command.
    typedef struct packed {
        avm_addr_t address;
        logic      read;
        logic      write;
        avm_data_t writedata;
    } avm_cmd_t;

    typedef enum logic [2:0] {
        poll_rx,
        get_n,
        get_d,
        get_c,
        wait_core,
        poll_tx,
        put
    } ctrl_state_t;

endpackage

// ==== verilog/rsa_mod_prep.sv ====
`timescale 1ns/1ps

module rsa_mod_prep (
    input  logic               avm_clk,
    input  logic               avm_rst,
    input  logic               start,
    input  rsa_pkg::rsa_word_t a,
    input  rsa_pkg::rsa_word_t n,
    output rsa_pkg::rsa_word_t result,
    output logic               done
);

    logic busy;
    rsa_pkg::rsa_cnt_t cnt;
    rsa_pkg::rsa_word_t acc;
    logic [rsa_pkg::rsa_width:0] dbl;
    logic [rsa_pkg::rsa_width:0] dbl_sub;

    // acc stays below n, so doubling never needs more than one extra bit.
    assign dbl = {acc, 1'b0};
    assign dbl_sub = (dbl >= {1'b0, n}) ? dbl - {1'b0, n} : dbl;
    assign result = acc;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy <= 1'b0;
            cnt <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == rsa_pkg::rsa_cnt_t'(rsa_pkg::rsa_width - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (start) begin
            acc <= a;
        end else if (busy) begin
            acc <= dbl_sub[rsa_pkg::rsa_width-1:0];
        end
    end

    start_idle_a: assert property (@(posedge avm_clk) disable iff (avm_rst)
        start |-> !busy);

endmodule

// ==== verilog/rsa_modexp_core.sv ====
`timescale 1ns/1ps

module rsa_modexp_core (
    input  logic               avm_clk,
    input  logic               avm_rst,
    input  logic               start,
    input  rsa_pkg::rsa_word_t cipher,
    input  rsa_pkg::rsa_word_t exponent,
    input  rsa_pkg::rsa_word_t modulus,
    output rsa_pkg::rsa_word_t plaintext,
    output logic               done
);

    rsa_pkg::core_state_t state;
    rsa_pkg::rsa_cnt_t round;
    logic prep_start;
    logic mult_start;
    logic prep_done;
    logic mul_done;
    logic sq_done;
    rsa_pkg::rsa_word_t prep_res;
    rsa_pkg::rsa_word_t mul_res;
    rsa_pkg::rsa_word_t sq_res;
    rsa_pkg::rsa_word_t m;
    rsa_pkg::rsa_word_t t;
    rsa_pkg::rsa_word_t e_sh;

    rsa_mod_prep u_prep (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (prep_start),
        .a       (cipher),
        .n       (modulus),
        .result  (prep_res),
        .done    (prep_done)
    );

    // m stays in plain form, so mont(m, t) with t in Montgomery form is m*t mod n.
    rsa_mont_mult u_mul (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mult_start),
        .a       (m),
        .b       (t),
        .n       (modulus),
        .result  (mul_res),
        .done    (mul_done)
    );

    rsa_mont_mult u_sq (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mult_start),
        .a       (t),
        .b       (t),
        .n       (modulus),
        .result  (sq_res),
        .done    (sq_done)
    );

    assign plaintext = m;
    assign done = (state == rsa_pkg::done);

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state <= rsa_pkg::idle;
            round <= '0;
            prep_start <= 1'b0;
            mult_start <= 1'b0;
        end else begin
            prep_start <= 1'b0;
            mult_start <= 1'b0;
            case (state)
                rsa_pkg::idle: begin
                    if (start) begin
                        prep_start <= 1'b1;
                        state <= rsa_pkg::prep;
                    end
                end
                rsa_pkg::prep: begin
                    if (prep_done) begin
                        mult_start <= 1'b1;
                        round <= '0;
                        state <= rsa_pkg::loop;
                    end
                end
                rsa_pkg::loop: begin
                    if (sq_done) begin
                        if (round == rsa_pkg::rsa_cnt_t'(rsa_pkg::rsa_width - 1)) begin
                            state <= rsa_pkg::done;
                        end else begin
                            round <= round + 1'b1;
                            mult_start <= 1'b1;
                        end
                    end
                end
                default: state <= rsa_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        if (state == rsa_pkg::idle && start) begin
            m <= rsa_pkg::rsa_word_t'(1);
            e_sh <= exponent;
        end
        if (state == rsa_pkg::prep && prep_done) begin
            t <= prep_res;
        end
        if (state == rsa_pkg::loop && sq_done) begin
            t <= sq_res;
            e_sh <= e_sh >> 1;
            if (e_sh[0]) begin
                m <= mul_res;
            end
        end
    end

    mult_in_step_a: assert property (@(posedge avm_clk) disable iff (avm_rst)
        mul_done == sq_done);

endmodule

// ==== verilog/rsa_mont_mult.sv ====
`timescale 1ns/1ps

module rsa_mont_mult (
    input  logic               avm_clk,
    input  logic               avm_rst,
    input  logic               start,
    input  rsa_pkg::rsa_word_t a,
    input  rsa_pkg::rsa_word_t b,
    input  rsa_pkg::rsa_word_t n,
    output rsa_pkg::rsa_word_t result,
    output logic               done
);

    logic busy;
    rsa_pkg::rsa_cnt_t cnt;
    rsa_pkg::rsa_word_t a_sh;
    rsa_pkg::rsa_word_t b_r;
    rsa_pkg::rsa_word_t n_r;
    logic [rsa_pkg::rsa_width:0] acc;
    logic [rsa_pkg::rsa_width:0] acc_cur;
    logic a_bit;
    rsa_pkg::rsa_word_t b_cur;
    rsa_pkg::rsa_word_t n_cur;
    logic [rsa_pkg::rsa_width+1:0] sum_b;
    logic [rsa_pkg::rsa_width+1:0] sum_n;
    logic [rsa_pkg::rsa_width:0] acc_nxt;
    rsa_pkg::rsa_word_t acc_sub;
    logic last_step;

    // step 0 runs in the start cycle straight from the inputs.
    always_comb begin
        acc_cur = start ? '0 : acc;
        a_bit = start ? a[0] : a_sh[0];
        b_cur = start ? b : b_r;
        n_cur = start ? n : n_r;
        sum_b = acc_cur + (a_bit ? b_cur : '0);
        sum_n = sum_b + (sum_b[0] ? n_cur : '0);
        acc_nxt = sum_n[rsa_pkg::rsa_width+1:1];
        acc_sub = acc[rsa_pkg::rsa_width-1:0] - n_r;
    end

    // after 256 halvings acc is below 2n, one subtract finishes the job.
    assign last_step = (cnt == rsa_pkg::rsa_cnt_t'(rsa_pkg::rsa_width));

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy <= 1'b0;
            cnt <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt <= rsa_pkg::rsa_cnt_t'(1);
            end else if (busy) begin
                if (last_step) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (start) begin
            acc <= acc_nxt;
            a_sh <= a >> 1;
            b_r <= b;
            n_r <= n;
        end else if (busy) begin
            if (last_step) begin
                result <= (acc >= {1'b0, n_r}) ? acc_sub : acc[rsa_pkg::rsa_width-1:0];
            end else begin
                acc <= acc_nxt;
                a_sh <= a_sh >> 1;
            end
        end
    end

    start_idle_a: assert property (@(posedge avm_clk) disable iff (avm_rst)
        start |-> !busy);

endmodule

// ==== verilog/rsa_pkg.sv ====
package rsa_pkg;

    // operand width of the RSA-256 datapath.
    localparam int rsa_width = 256;

    // iteration counters must reach 256 inclusive.
    localparam int rsa_cnt_width = 9;

    typedef logic [rsa_width-1:0] rsa_word_t;
    typedef logic [rsa_cnt_width-1:0] rsa_cnt_t;

    // sequencer of the modular exponentiation core.
    typedef enum logic [1:0] {
        idle,
        prep,
        loop,
        done
    } core_state_t;

endpackage

// ==== verilog/rsa_uart_ctrl.sv ====
`timescale 1ns/1ps

module rsa_uart_ctrl (
    input  logic                   avm_clk,
    input  logic                   avm_rst,
    output avm_uart_pkg::avm_cmd_t  cmd,
    input  avm_uart_pkg::avm_data_t readdata,
    input  logic                   waitrequest,
    output logic                   core_start,
    output rsa_pkg::rsa_word_t      cipher,
    output rsa_pkg::rsa_word_t      exponent,
    output rsa_pkg::rsa_word_t      modulus,
    input  rsa_pkg::rsa_word_t      plaintext,
    input  logic                   core_done
);

    avm_uart_pkg::ctrl_state_t state;
    avm_uart_pkg::ctrl_state_t phase;
    logic [4:0] byte_cnt;
    rsa_pkg::rsa_word_t tx_sh;
    avm_uart_pkg::byte_t rx_byte;
    logic last_in;
    logic last_out;

    assign rx_byte = readdata[7:0];
    assign last_in = (byte_cnt == 5'(avm_uart_pkg::key_bytes - 1));
    assign last_out = (byte_cnt == 5'(avm_uart_pkg::out_bytes - 1));

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state <= avm_uart_pkg::poll_rx;
            phase <= avm_uart_pkg::get_n;
            byte_cnt <= '0;
            core_start <= 1'b0;
            cmd <= '{address: avm_uart_pkg::status_base, read: 1'b1, write: 1'b0,
                     writedata: '0};
        end else begin
            core_start <= 1'b0;
            case (state)
                avm_uart_pkg::poll_rx: begin
                    if (!waitrequest && readdata[avm_uart_pkg::rx_ok_bit]) begin
                        cmd.address <= avm_uart_pkg::rx_base;
                        state <= phase;
                    end
                end
                avm_uart_pkg::get_n, avm_uart_pkg::get_d, avm_uart_pkg::get_c: begin
                    if (!waitrequest) begin
                        // the counter wraps to zero after the 32nd byte.
                        byte_cnt <= byte_cnt + 1'b1;
                        cmd.address <= avm_uart_pkg::status_base;
                        state <= avm_uart_pkg::poll_rx;
                        if (last_in) begin
                            if (state == avm_uart_pkg::get_n) begin
                                phase <= avm_uart_pkg::get_d;
                            end else if (state == avm_uart_pkg::get_d) begin
                                phase <= avm_uart_pkg::get_c;
                            end else begin
                                core_start <= 1'b1;
                                cmd.read <= 1'b0;
                                state <= avm_uart_pkg::wait_core;
                            end
                        end
                    end
                end
                avm_uart_pkg::wait_core: begin
                    if (core_done) begin
                        cmd.read <= 1'b1;
                        state <= avm_uart_pkg::poll_tx;
                    end
                end
                avm_uart_pkg::poll_tx: begin
                    if (!waitrequest && readdata[avm_uart_pkg::tx_ok_bit]) begin
                        cmd <= '{address: avm_uart_pkg::tx_base, read: 1'b0, write: 1'b1,
                                 writedata: avm_uart_pkg::avm_data_t'(
                                     tx_sh[8*avm_uart_pkg::out_bytes-1 -: 8])};
                        state <= avm_uart_pkg::put;
                    end
                end
                avm_uart_pkg::put: begin
                    if (!waitrequest) begin
                        cmd <= '{address: avm_uart_pkg::status_base, read: 1'b1, write: 1'b0,
                                 writedata: '0};
                        if (last_out) begin
                            byte_cnt <= '0;
                            state <= avm_uart_pkg::poll_rx;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                            state <= avm_uart_pkg::poll_tx;
                        end
                    end
                end
                default: state <= avm_uart_pkg::poll_rx;
            endcase
        end
    end

    // bytes arrive most significant first, so each one enters at the bottom.
    always_ff @(posedge avm_clk) begin
        if (!waitrequest) begin
            case (state)
                avm_uart_pkg::get_n: modulus <= {modulus[rsa_pkg::rsa_width-9:0], rx_byte};
                avm_uart_pkg::get_d: exponent <= {exponent[rsa_pkg::rsa_width-9:0], rx_byte};
                avm_uart_pkg::get_c: cipher <= {cipher[rsa_pkg::rsa_width-9:0], rx_byte};
                avm_uart_pkg::put: tx_sh <= tx_sh << 8;
                default: ;
            endcase
        end
        if (state == avm_uart_pkg::wait_core && core_done) begin
            tx_sh <= plaintext;
        end
    end

    rw_excl_a: assert property (@(posedge avm_clk) disable iff (avm_rst)
        !(cmd.read && cmd.write));

    cmd_hold_a: assert property (@(posedge avm_clk) disable iff (avm_rst)
        (cmd.read || cmd.write) && waitrequest |=> $stable(cmd));

endmodule

// ==== verilog/rsa_uart_top.sv ====
`timescale 1ns/1ps

module rsa_uart_top (
    input  logic                   avm_clk,
    input  logic                   avm_rst,
    output avm_uart_pkg::avm_addr_t avm_address,
    output logic                   avm_read,
    input  avm_uart_pkg::avm_data_t avm_readdata,
    output logic                   avm_write,
    output avm_uart_pkg::avm_data_t avm_writedata,
    input  logic                   avm_waitrequest
);

    avm_uart_pkg::avm_cmd_t cmd;
    logic core_start;
    logic core_done;
    rsa_pkg::rsa_word_t cipher;
    rsa_pkg::rsa_word_t exponent;
    rsa_pkg::rsa_word_t modulus;
    rsa_pkg::rsa_word_t plaintext;

    assign avm_address = cmd.address;
    assign avm_read = cmd.read;
    assign avm_write = cmd.write;
    assign avm_writedata = cmd.writedata;

    rsa_uart_ctrl u_ctrl (
        .avm_clk     (avm_clk),
        .avm_rst     (avm_rst),
        .cmd         (cmd),
        .readdata    (avm_readdata),
        .waitrequest (avm_waitrequest),
        .core_start  (core_start),
        .cipher      (cipher),
        .exponent    (exponent),
        .modulus     (modulus),
        .plaintext   (plaintext),
        .core_done   (core_done)
    );

    rsa_modexp_core u_core (
        .avm_clk   (avm_clk),
        .avm_rst   (avm_rst),
        .start     (core_start),
        .cipher    (cipher),
        .exponent  (exponent),
        .modulus   (modulus),
        .plaintext (plaintext),
        .done      (core_done)
    );

endmodule
